// ==== mock_lce.f ====
design/lce_pkg.sv
design/lce_word_align.sv
design/lce_data_array.sv
design/lce_tag_array.sv
design/lce_ctrl.sv
design/mock_lce.sv
test/lce_checker.sv
test/lce_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lce_tb -f mock_lce.f

if ./obj_dir/Vlce_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

// ==== test/lce_tb.sv ====
`timescale 1ns/1ps

module lce_tb;
  import lce_pkg::*;

  localparam int sets_p = 8;
  localparam int ways_p = 2;
  localparam int block_width_p = 256;
  localparam int timeout_lp = 200;

  logic clk_i = 1'b0;
  logic reset_i;
  logic tr_v_i, tr_ready_o, tr_v_o, tr_ready_i;
  tr_op_e tr_op_i;
  paddr_t tr_addr_i, tr_addr_o, req_addr_o, cmd_addr_i, resp_addr_o;
  dword_t tr_data_i, tr_data_o;
  logic req_v_o, req_ready_i, cmd_v_i, cmd_ready_o, resp_v_o, resp_ready_i;
  req_type_e req_type_o;
  cmd_type_e cmd_type_i;
  resp_type_e resp_type_o;
  logic [0:0] req_way_o, cmd_way_i;
  logic [block_width_p-1:0] cmd_data_i, resp_data_o;

  // reference image of the cache, set index in bits 7:5, tag in 31:8
  logic [block_width_p-1:0] line_m [sets_p][ways_p];
  logic [23:0] tag_m [sets_p][ways_p];
  coh_state_e state_m [sets_p][ways_p];
  int rr_m [sets_p];
  int errors = 0;

  // payload seen at the last output handshake
  paddr_t got_addr;
  int got_type;
  int got_way;
  logic [block_width_p-1:0] got_data;

  tr_op_e all_ops [12] = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu, op_ldu,
                           op_sb, op_sh, op_sw, op_sd};

  mock_lce #(
    .sets_p(sets_p), .ways_p(ways_p), .block_width_p(block_width_p)
  ) mock_lce_inst (.*);

  always #2 clk_i = ~clk_i;

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic give_up(string what);
    $display("timeout while waiting in %s", what);
    $display("checks failed: %0d, timeouts: 1", errors);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic check_value(string name, logic [255:0] exp, logic [255:0] act);
    value_ok: assert (exp === act) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [255:0] random_line();
    logic [255:0] l;
    for (int i = 0; i < 8; i++) begin
      l[32*i +: 32] = $urandom;
    end
    return l;
  endfunction

  // field at the byte offset, extended unless the op is unsigned
  function automatic dword_t expect_load(tr_op_e op, paddr_t addr, logic [255:0] line);
    dword_t f;
    logic sgn;
    f = line[addr[4:3]*64 +: 64] >> (addr[2:0]*8);
    sgn = ~op[2];
    case (op[1:0])
      2'd0: f = {{56{sgn & f[7]}}, f[7:0]};
      2'd1: f = {{48{sgn & f[15]}}, f[15:0]};
      2'd2: f = {{32{sgn & f[31]}}, f[31:0]};
      default: f = f;
    endcase
    return f;
  endfunction

  task automatic send_trace(tr_op_e op, paddr_t addr, dword_t data, string name);
    int n = 0;
    tr_v_i = 1'b1;
    tr_op_i = op;
    tr_addr_i = addr;
    tr_data_i = data;
    @(negedge clk_i);
    while (!tr_ready_o) begin
      n++;
      if (n > timeout_lp) give_up({name, " trace input"});
      @(negedge clk_i);
    end
    step();
    tr_v_i = 1'b0;
  endtask

  task automatic send_cmd(cmd_type_e t, paddr_t a, int w, logic [255:0] d, string name);
    int n = 0;
    cmd_v_i = 1'b1;
    cmd_type_i = t;
    cmd_addr_i = a;
    cmd_way_i = 1'(w);
    cmd_data_i = d;
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      n++;
      if (n > timeout_lp) give_up({name, " directory command"});
      @(negedge clk_i);
    end
    step();
    cmd_v_i = 1'b0;
  endtask

  // ch 0 trace result, 1 request, 2 response; ready held low for a random stretch
  task automatic take_output(int ch, string name);
    int n = 0;
    logic v = 1'b0;
    repeat ($urandom % 4) step();
    case (ch)
      0: tr_ready_i = 1'b1;
      1: req_ready_i = 1'b1;
      default: resp_ready_i = 1'b1;
    endcase
    while (!v) begin
      @(negedge clk_i);
      case (ch)
        0: v = tr_v_o;
        1: v = req_v_o;
        default: v = resp_v_o;
      endcase
      if (ch == 0) begin
        no_request: assert (!req_v_o) else begin
          errors++;
          $display("%s: unexpected directory request while waiting for result", name);
        end
      end
      n++;
      if (!v && n > timeout_lp) give_up({name, " output handshake"});
    end
    got_addr = ch == 0 ? tr_addr_o : (ch == 1 ? req_addr_o : resp_addr_o);
    got_type = ch == 1 ? int'(req_type_o) : int'(resp_type_o);
    got_way = int'(req_way_o);
    got_data = ch == 0 ? 256'(tr_data_o) : resp_data_o;
    step();
    tr_ready_i = 1'b0;
    req_ready_i = 1'b0;
    resp_ready_i = 1'b0;
  endtask

  task automatic do_access(string name, tr_op_e op, paddr_t addr, dword_t data);
    int s = int'(addr[7:5]);
    int w = 0;
    logic hit = 1'b0;
    paddr_t blk = {addr[31:5], 5'b0};
    for (int i = 0; i < ways_p; i++) begin
      if (state_m[s][i] != coh_i && tag_m[s][i] == addr[31:8]) begin
        hit = 1'b1;
        w = i;
      end
    end
    send_trace(op, addr, data, name);
    if (!hit) begin
      w = rr_m[s];
      take_output(1, name);
      check_value({name, " req_type"}, 256'(op[3] ? req_wr : req_rd), 256'(got_type));
      check_value({name, " req_addr"}, 256'(blk), 256'(got_addr));
      check_value({name, " req_way"}, 256'(w), 256'(got_way));
      line_m[s][w] = random_line();
      tag_m[s][w] = addr[31:8];
      state_m[s][w] = coh_e;
      rr_m[s] = (rr_m[s] + 1) % ways_p;
      repeat ($urandom % 3) step();
      send_cmd(cmd_fill, blk, w, line_m[s][w], name);
      take_output(2, name);
      check_value({name, " ack type"}, 256'(resp_coh_ack), 256'(got_type));
      check_value({name, " ack addr"}, 256'(blk), 256'(got_addr));
    end
    take_output(0, name);
    check_value({name, " tr_addr"}, 256'(addr), 256'(got_addr));
    if (op[3]) begin
      check_value({name, " store result"}, '0, got_data);
      for (int b = 0; b < (1 << op[1:0]); b++) begin
        line_m[s][w][8*(int'(addr[4:0])+b) +: 8] = data[8*b +: 8];
      end
      state_m[s][w] = coh_m;
    end else begin
      check_value({name, " load data"}, 256'(expect_load(op, addr, line_m[s][w])), got_data);
    end
  endtask

  task automatic do_wb(string name, paddr_t addr);
    int s = int'(addr[7:5]);
    int w = 0;
    paddr_t blk = {addr[31:5], 5'b0};
    for (int i = 0; i < ways_p; i++) begin
      if (state_m[s][i] != coh_i && tag_m[s][i] == addr[31:8]) w = i;
    end
    send_cmd(cmd_wb, blk, w, '0, name);
    take_output(2, name);
    check_value({name, " wb addr"}, 256'(blk), 256'(got_addr));
    if (state_m[s][w] == coh_m) begin
      check_value({name, " wb type"}, 256'(resp_wb), 256'(got_type));
      check_value({name, " wb data"}, line_m[s][w], got_data);
      state_m[s][w] = coh_e;
    end else begin
      check_value({name, " wb type"}, 256'(resp_null_wb), 256'(got_type));
    end
  endtask

  initial begin
    tr_op_e op;
    paddr_t addr;
    logic [4:0] off;
    void'($urandom(69297));
    reset_i = 1'b1;
    tr_v_i = 1'b0;
    tr_op_i = op_lb;
    tr_addr_i = '0;
    tr_data_i = '0;
    tr_ready_i = 1'b0;
    req_ready_i = 1'b0;
    cmd_v_i = 1'b0;
    cmd_type_i = cmd_fill;
    cmd_addr_i = '0;
    cmd_way_i = '0;
    cmd_data_i = '0;
    resp_ready_i = 1'b0;
    for (int s = 0; s < sets_p; s++) begin
      rr_m[s] = 0;
      for (int w = 0; w < ways_p; w++) begin
        state_m[s][w] = coh_i;
        tag_m[s][w] = '0;
        line_m[s][w] = '0;
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    step();

    do_access("load_miss", op_lw, 32'h0000_1044, '0);
    do_access("hit_lb", op_lb, 32'h0000_1047, '0);
    do_access("hit_lbu", op_lbu, 32'h0000_1047, '0);
    do_access("hit_lh", op_lh, 32'h0000_104a, '0);
    do_access("hit_lhu", op_lhu, 32'h0000_105e, '0);
    do_access("hit_lw", op_lw, 32'h0000_1054, '0);
    do_access("hit_lwu", op_lwu, 32'h0000_1054, '0);
    do_access("hit_ld", op_ld, 32'h0000_1058, '0);
    do_access("hit_ldu", op_ldu, 32'h0000_1048, '0);
    do_access("store_hit", op_sw, 32'h0000_1050, 64'h0123_4567_89ab_cdef);
    do_wb("store_wb", 32'h0000_1040);
    do_access("clean_fill", op_lw, 32'h0000_2064, '0);
    do_wb("clean_wb", 32'h0000_2060);
    do_access("store_miss", op_sd, 32'h0000_30a8, 64'hfeed_face_cafe_beef);
    do_access("store_miss_read", op_ld, 32'h0000_30a8, '0);
    // four lines in set 6 walk the round-robin victim
    do_access("same_set_0", op_lw, 32'h0000_40c0, '0);
    do_access("same_set_1", op_lw, 32'h0000_50c0, '0);
    do_access("same_set_2", op_lw, 32'h0000_60c0, '0);
    do_access("same_set_3", op_lw, 32'h0000_70c0, '0);

    // three tags over all sets force evictions
    for (int i = 0; i < 40; i++) begin
      op = all_ops[$urandom % 12];
      off = 5'($urandom) & ~5'((1 << op[1:0]) - 1);
      addr = {24'(32'h100 + $urandom % 3), 3'($urandom), off};
      do_access("random", op, addr, {$urandom, $urandom});
      // the directory only writes back a line the cache holds
      if ($urandom % 5 == 0) begin
        do_wb("random_wb", {addr[31:5], 5'b0});
      end
    end

    $display("checks failed: %0d, timeouts: 0", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== test/lce_checker.sv ====
`timescale 1ns/1ps

module lce_checker #(
  parameter int ways_p = 2,
  parameter int block_width_p = 256,
  localparam int lg_ways_lp = $clog2(ways_p),
  localparam int offset_lp = $clog2(block_width_p / 8)
) (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     tr_v_o,
  input logic                     tr_ready_i,
  input lce_pkg::paddr_t          tr_addr_o,
  input lce_pkg::dword_t          tr_data_o,
  input logic                     req_v_o,
  input logic                     req_ready_i,
  input lce_pkg::req_type_e       req_type_o,
  input lce_pkg::paddr_t          req_addr_o,
  input logic [lg_ways_lp-1:0]    req_way_o,
  input logic                     resp_v_o,
  input logic                     resp_ready_i,
  input lce_pkg::resp_type_e      resp_type_o,
  input lce_pkg::paddr_t          resp_addr_o,
  input logic [block_width_p-1:0] resp_data_o
);

  // an offered transfer keeps valid and payload until it is taken
  tr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tr_v_o && !tr_ready_i |=> tr_v_o && $stable({tr_addr_o, tr_data_o}))
    else $error("trace result dropped or changed before it was taken");

  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o && !req_ready_i |=> req_v_o && $stable({req_type_o, req_addr_o, req_way_o}))
    else $error("request dropped or changed before it was taken");

  resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable({resp_type_o, resp_addr_o, resp_data_o}))
    else $error("response dropped or changed before it was taken");

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !tr_v_o && !req_v_o && !resp_v_o)
    else $error("valid output high in the cycle after reset");

  req_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_o |-> req_addr_o[offset_lp-1:0] == '0)
    else $error("request address not block aligned");

endmodule

bind mock_lce lce_checker #(
  .ways_p(ways_p),
  .block_width_p(block_width_p)
) checker_inst (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .tr_v_o(tr_v_o),
  .tr_ready_i(tr_ready_i),
  .tr_addr_o(tr_addr_o),
  .tr_data_o(tr_data_o),
  .req_v_o(req_v_o),
  .req_ready_i(req_ready_i),
  .req_type_o(req_type_o),
  .req_addr_o(req_addr_o),
  .req_way_o(req_way_o),
  .resp_v_o(resp_v_o),
  .resp_ready_i(resp_ready_i),
  .resp_type_o(resp_type_o),
  .resp_addr_o(resp_addr_o),
  .resp_data_o(resp_data_o)
);

// ==== design/mock_lce.sv ====
`timescale 1ns/1ps

module mock_lce #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_width_p = 256,
  localparam int lg_ways_lp = $clog2(ways_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     tr_v_i,
  input  lce_pkg::tr_op_e          tr_op_i,
  input  lce_pkg::paddr_t          tr_addr_i,
  input  lce_pkg::dword_t          tr_data_i,
  output logic                     tr_ready_o,
  output logic                     tr_v_o,
  output lce_pkg::paddr_t          tr_addr_o,
  output lce_pkg::dword_t          tr_data_o,
  input  logic                     tr_ready_i,
  output logic                     req_v_o,
  output lce_pkg::req_type_e       req_type_o,
  output lce_pkg::paddr_t          req_addr_o,
  output logic [lg_ways_lp-1:0]    req_way_o,
  input  logic                     req_ready_i,
  input  logic                     cmd_v_i,
  input  lce_pkg::cmd_type_e       cmd_type_i,
  input  lce_pkg::paddr_t          cmd_addr_i,
  input  logic [lg_ways_lp-1:0]    cmd_way_i,
  input  logic [block_width_p-1:0] cmd_data_i,
  output logic                     cmd_ready_o,
  output logic                     resp_v_o,
  output lce_pkg::resp_type_e      resp_type_o,
  output lce_pkg::paddr_t          resp_addr_o,
  output logic [block_width_p-1:0] resp_data_o,
  input  logic                     resp_ready_i
);
  import lce_pkg::*;

  localparam int lg_sets_lp = $clog2(sets_p);
  localparam int tag_width_lp = $bits(paddr_t) - lg_sets_lp - $clog2(block_width_p / 8);

  logic tag_hit, tag_we, victim_adv, data_we, data_fill;
  logic [lg_ways_lp-1:0] tag_hit_way, victim_way, way;
  logic [lg_sets_lp-1:0] set;
  logic [tag_width_lp-1:0] tag;
  coh_state_e tag_hit_state, sel_state, tag_state;
  logic [block_width_p-1:0] rd_block, fill_block, store_mask, store_block;
  tr_op_e op;
  paddr_t addr;
  dword_t store_data, load_dword;

  lce_ctrl #(
    .sets_p(sets_p), .ways_p(ways_p), .block_width_p(block_width_p)
  ) ctrl_inst (
    .tag_hit_i(tag_hit), .tag_hit_way_i(tag_hit_way), .tag_hit_state_i(tag_hit_state),
    .victim_way_i(victim_way), .sel_state_i(sel_state), .rd_block_i(rd_block),
    .load_dword_i(load_dword), .set_o(set), .way_o(way), .tag_we_o(tag_we),
    .tag_state_o(tag_state), .tag_o(tag), .victim_adv_o(victim_adv),
    .data_we_o(data_we), .data_fill_o(data_fill), .fill_block_o(fill_block),
    .op_o(op), .addr_o(addr), .store_data_o(store_data),
    .*
  );

  lce_tag_array #(
    .sets_p(sets_p), .ways_p(ways_p), .block_width_p(block_width_p)
  ) tag_inst (
    .clk_i(clk_i), .reset_i(reset_i), .lookup_addr_i(addr),
    .set_i(set), .way_i(way), .tag_we_i(tag_we), .tag_state_i(tag_state),
    .tag_i(tag), .victim_adv_i(victim_adv),
    .hit_o(tag_hit), .hit_way_o(tag_hit_way), .hit_state_o(tag_hit_state),
    .victim_way_o(victim_way), .sel_state_o(sel_state)
  );

  lce_data_array #(
    .sets_p(sets_p), .ways_p(ways_p), .block_width_p(block_width_p)
  ) data_inst (
    .clk_i(clk_i), .reset_i(reset_i), .set_i(set), .way_i(way),
    .we_i(data_we), .fill_i(data_fill), .fill_block_i(fill_block),
    .store_mask_i(store_mask), .store_block_i(store_block), .rd_block_o(rd_block)
  );

  lce_word_align #(
    .block_width_p(block_width_p)
  ) align_inst (
    .op_i(op), .addr_i(addr), .store_data_i(store_data), .rd_block_i(rd_block),
    .load_dword_o(load_dword), .store_mask_o(store_mask), .store_block_o(store_block)
  );

endmodule

// ==== design/lce_ctrl.sv ====
`timescale 1ns/1ps

module lce_ctrl #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_width_p = 256,
  localparam int lg_sets_lp = $clog2(sets_p),
  localparam int lg_ways_lp = $clog2(ways_p),
  localparam int offset_lp = $clog2(block_width_p / 8),
  localparam int tag_width_lp = $bits(lce_pkg::paddr_t) - lg_sets_lp - offset_lp
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     tr_v_i,
  input  lce_pkg::tr_op_e          tr_op_i,
  input  lce_pkg::paddr_t          tr_addr_i,
  input  lce_pkg::dword_t          tr_data_i,
  output logic                     tr_ready_o,
  output logic                     tr_v_o,
  output lce_pkg::paddr_t          tr_addr_o,
  output lce_pkg::dword_t          tr_data_o,
  input  logic                     tr_ready_i,
  output logic                     req_v_o,
  output lce_pkg::req_type_e       req_type_o,
  output lce_pkg::paddr_t          req_addr_o,
  output logic [lg_ways_lp-1:0]    req_way_o,
  input  logic                     req_ready_i,
  input  logic                     cmd_v_i,
  input  lce_pkg::cmd_type_e       cmd_type_i,
  input  lce_pkg::paddr_t          cmd_addr_i,
  input  logic [lg_ways_lp-1:0]    cmd_way_i,
  input  logic [block_width_p-1:0] cmd_data_i,
  output logic                     cmd_ready_o,
  output logic                     resp_v_o,
  output lce_pkg::resp_type_e      resp_type_o,
  output lce_pkg::paddr_t          resp_addr_o,
  output logic [block_width_p-1:0] resp_data_o,
  input  logic                     resp_ready_i,
  input  logic                     tag_hit_i,
  input  logic [lg_ways_lp-1:0]    tag_hit_way_i,
  input  lce_pkg::coh_state_e      tag_hit_state_i,
  input  logic [lg_ways_lp-1:0]    victim_way_i,
  input  lce_pkg::coh_state_e      sel_state_i,
  input  logic [block_width_p-1:0] rd_block_i,
  input  lce_pkg::dword_t          load_dword_i,
  output logic [lg_sets_lp-1:0]    set_o,
  output logic [lg_ways_lp-1:0]    way_o,
  output logic                     tag_we_o,
  output lce_pkg::coh_state_e      tag_state_o,
  output logic [tag_width_lp-1:0]  tag_o,
  output logic                     victim_adv_o,
  output logic                     data_we_o,
  output logic                     data_fill_o,
  output logic [block_width_p-1:0] fill_block_o,
  output lce_pkg::tr_op_e          op_o,
  output lce_pkg::paddr_t          addr_o,
  output lce_pkg::dword_t          store_data_o
);
  import lce_pkg::*;

  typedef enum logic [3:0] {
    s_reset, s_idle, s_lookup, s_hit_load, s_hit_store, s_miss_req,
    s_fill_write, s_fill_ack, s_miss_finish, s_wb_read, s_wb_send
  } state_e;

  state_e state_r, state_n;
  logic miss_r, miss_n;

  // accepted trace command and miss record
  tr_op_e tr_op_r;
  paddr_t tr_addr_r;
  dword_t tr_data_r;
  logic [lg_ways_lp-1:0] hit_way_r, victim_r;

  // last directory command, its way is the fill way of a miss
  paddr_t cmd_addr_r;
  logic [lg_ways_lp-1:0] cmd_way_r;
  logic [block_width_p-1:0] cmd_data_r;

  logic tr_take, cmd_take, is_store, line_m;

  assign is_store = tr_op_r[3];
  assign line_m = (sel_state_i == coh_m);

  // directory commands win over new trace commands
  assign cmd_ready_o = (state_r == s_idle);
  assign tr_ready_o = (state_r == s_idle) & ~cmd_v_i & ~miss_r;
  assign cmd_take = cmd_ready_o & cmd_v_i;
  assign tr_take = tr_ready_o & tr_v_i;

  assign op_o = tr_op_r;
  assign addr_o = tr_addr_r;
  assign store_data_o = tr_data_r;
  assign fill_block_o = cmd_data_r;
  assign tr_addr_o = tr_addr_r;
  assign req_type_o = is_store ? req_wr : req_rd;
  assign req_addr_o = tr_addr_r & ~paddr_t'(block_width_p / 8 - 1);
  assign req_way_o = victim_r;
  assign resp_addr_o = cmd_addr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_reset;
      miss_r <= 1'b0;
    end else begin
      state_r <= state_n;
      miss_r <= miss_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tr_take) begin
      tr_op_r <= tr_op_i;
      tr_addr_r <= tr_addr_i;
      tr_data_r <= tr_data_i;
    end
    if (cmd_take) begin
      cmd_addr_r <= cmd_addr_i;
      cmd_way_r <= cmd_way_i;
      cmd_data_r <= cmd_data_i;
    end
    if (state_r == s_lookup) begin
      hit_way_r <= tag_hit_way_i;
      victim_r <= victim_way_i;
    end
  end

  always_comb begin
    state_n = state_r;
    miss_n = miss_r;
    set_o = tr_addr_r[offset_lp +: lg_sets_lp];
    way_o = hit_way_r;
    tag_we_o = 1'b0;
    tag_state_o = coh_m;
    tag_o = tr_addr_r[$bits(paddr_t)-1 -: tag_width_lp];
    victim_adv_o = 1'b0;
    data_we_o = 1'b0;
    data_fill_o = 1'b0;
    tr_v_o = 1'b0;
    tr_data_o = '0;
    req_v_o = 1'b0;
    resp_v_o = 1'b0;
    resp_type_o = resp_coh_ack;
    resp_data_o = '0;

    case (state_r)
      s_reset: begin
        state_n = s_idle;
      end
      s_idle: begin
        if (cmd_take) begin
          state_n = (cmd_type_i == cmd_fill) ? s_fill_write : s_wb_read;
        end else if (tr_take) begin
          state_n = s_lookup;
        end
      end
      s_lookup: begin
        if (tag_hit_i) begin
          state_n = is_store ? s_hit_store : s_hit_load;
        end else begin
          miss_n = 1'b1;
          state_n = s_miss_req;
        end
      end
      s_hit_load: begin
        tr_v_o = 1'b1;
        tr_data_o = load_dword_i;
        if (tr_ready_i) begin
          state_n = s_idle;
        end
      end
      s_hit_store: begin
        // merge and E to M move land with the result transfer
        tr_v_o = 1'b1;
        data_we_o = tr_ready_i;
        tag_we_o = tr_ready_i & (tag_hit_state_i == coh_e);
        if (tr_ready_i) begin
          state_n = s_idle;
        end
      end
      s_miss_req: begin
        req_v_o = 1'b1;
        if (req_ready_i) begin
          state_n = s_idle;
        end
      end
      s_fill_write: begin
        set_o = cmd_addr_r[offset_lp +: lg_sets_lp];
        way_o = cmd_way_r;
        tag_o = cmd_addr_r[$bits(paddr_t)-1 -: tag_width_lp];
        tag_state_o = coh_e;
        tag_we_o = 1'b1;
        data_we_o = 1'b1;
        data_fill_o = 1'b1;
        state_n = s_fill_ack;
      end
      s_fill_ack: begin
        resp_v_o = 1'b1;
        if (resp_ready_i) begin
          state_n = s_miss_finish;
        end
      end
      s_miss_finish: begin
        // replay the access on the freshly filled way
        way_o = cmd_way_r;
        tr_v_o = 1'b1;
        if (!is_store) begin
          tr_data_o = load_dword_i;
        end
        data_we_o = tr_ready_i & is_store;
        tag_we_o = tr_ready_i & is_store;
        victim_adv_o = tr_ready_i;
        if (tr_ready_i) begin
          miss_n = 1'b0;
          state_n = s_idle;
        end
      end
      s_wb_read: begin
        set_o = cmd_addr_r[offset_lp +: lg_sets_lp];
        way_o = cmd_way_r;
        state_n = s_wb_send;
      end
      s_wb_send: begin
        set_o = cmd_addr_r[offset_lp +: lg_sets_lp];
        way_o = cmd_way_r;
        tag_o = cmd_addr_r[$bits(paddr_t)-1 -: tag_width_lp];
        resp_v_o = 1'b1;
        resp_type_o = line_m ? resp_wb : resp_null_wb;
        if (line_m) begin
          resp_data_o = rd_block_i;
        end
        // line is clean again once its data has left
        tag_state_o = coh_e;
        tag_we_o = resp_ready_i & line_m;
        if (resp_ready_i) begin
          state_n = s_idle;
        end
      end
      default: begin
        state_n = s_idle;
      end
    endcase
  end

endmodule

// ==== design/lce_tag_array.sv ====
`timescale 1ns/1ps

module lce_tag_array #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_width_p = 256,
  localparam int lg_sets_lp = $clog2(sets_p),
  localparam int lg_ways_lp = $clog2(ways_p),
  localparam int offset_lp = $clog2(block_width_p / 8),
  localparam int tag_width_lp = $bits(lce_pkg::paddr_t) - lg_sets_lp - offset_lp
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  lce_pkg::paddr_t         lookup_addr_i,
  input  logic [lg_sets_lp-1:0]   set_i,
  input  logic [lg_ways_lp-1:0]   way_i,
  input  logic                    tag_we_i,
  input  lce_pkg::coh_state_e     tag_state_i,
  input  logic [tag_width_lp-1:0] tag_i,
  input  logic                    victim_adv_i,
  output logic                    hit_o,
  output logic [lg_ways_lp-1:0]   hit_way_o,
  output lce_pkg::coh_state_e     hit_state_o,
  output logic [lg_ways_lp-1:0]   victim_way_o,
  output lce_pkg::coh_state_e     sel_state_o
);
  import lce_pkg::*;

  logic [tag_width_lp-1:0] tag_r [sets_p][ways_p];
  coh_state_e state_r [sets_p][ways_p];
  // round-robin victim pointer per set
  logic [lg_ways_lp-1:0] rr_r [sets_p];
  logic [lg_sets_lp-1:0] lookup_set;
  logic [tag_width_lp-1:0] lookup_tag;

  assign lookup_set = lookup_addr_i[offset_lp +: lg_sets_lp];
  assign lookup_tag = lookup_addr_i[$bits(paddr_t)-1 -: tag_width_lp];
  assign victim_way_o = rr_r[lookup_set];
  assign sel_state_o = state_r[set_i][way_i];

  always_comb begin
    hit_o = 1'b0;
    hit_way_o = '0;
    hit_state_o = coh_i;
    for (int w = 0; w < ways_p; w++) begin
      if (state_r[lookup_set][w] != coh_i && tag_r[lookup_set][w] == lookup_tag) begin
        hit_o = 1'b1;
        hit_way_o = lg_ways_lp'(w);
        hit_state_o = state_r[lookup_set][w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        rr_r[s] <= '0;
        for (int w = 0; w < ways_p; w++) begin
          state_r[s][w] <= coh_i;
        end
      end
    end else begin
      if (tag_we_i) begin
        state_r[set_i][way_i] <= tag_state_i;
      end
      if (victim_adv_i) begin
        rr_r[set_i] <= (rr_r[set_i] == lg_ways_lp'(ways_p - 1)) ? '0 : rr_r[set_i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_r[set_i][way_i] <= tag_i;
    end
  end

endmodule

// ==== design/lce_data_array.sv ====
`timescale 1ns/1ps

module lce_data_array #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_width_p = 256,
  localparam int lg_sets_lp = $clog2(sets_p),
  localparam int lg_ways_lp = $clog2(ways_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [lg_sets_lp-1:0]    set_i,
  input  logic [lg_ways_lp-1:0]    way_i,
  input  logic                     we_i,
  input  logic                     fill_i,
  input  logic [block_width_p-1:0] fill_block_i,
  input  logic [block_width_p-1:0] store_mask_i,
  input  logic [block_width_p-1:0] store_block_i,
  output logic [block_width_p-1:0] rd_block_o
);

  // one line per set and way, set in the upper index bits
  logic [block_width_p-1:0] mem_r [sets_p*ways_p];
  logic [lg_sets_lp+lg_ways_lp-1:0] index;
  logic [block_width_p-1:0] wr_block;

  assign index = {set_i, way_i};
  assign rd_block_o = mem_r[index];

  // a fill replaces the line, a store keeps the bits outside its mask
  assign wr_block = fill_i ? fill_block_i
                           : (rd_block_o & ~store_mask_i) | (store_block_i & store_mask_i);

  always_ff @(posedge clk_i) begin
    if (we_i && !reset_i) begin
      mem_r[index] <= wr_block;
    end
  end

endmodule

// ==== design/lce_word_align.sv ====
`timescale 1ns/1ps

module lce_word_align #(
  parameter int block_width_p = 256
) (
  input  lce_pkg::tr_op_e          op_i,
  input  lce_pkg::paddr_t          addr_i,
  input  lce_pkg::dword_t          store_data_i,
  input  logic [block_width_p-1:0] rd_block_i,
  output lce_pkg::dword_t          load_dword_o,
  output logic [block_width_p-1:0] store_mask_o,
  output logic [block_width_p-1:0] store_block_o
);
  import lce_pkg::*;

  localparam int dwords_lp = block_width_p / $bits(dword_t);

  int unsigned dword_idx;
  logic [1:0] size;
  logic is_signed;
  logic [LG_DWORD_BYTES-1:0] size_low, byte_off;
  logic [7:0] byte_mask;
  dword_t dword_sel, shifted, bit_mask, placed;

  assign size = op_i[1:0];
  assign is_signed = ~op_i[2];
  assign dword_idx = (addr_i >> LG_DWORD_BYTES) & paddr_t'(dwords_lp - 1);

  // offset is rounded down to the access size
  assign size_low = LG_DWORD_BYTES'((1 << size) - 1);
  assign byte_off = addr_i[LG_DWORD_BYTES-1:0] & ~size_low;
  assign byte_mask = 8'(((1 << (1 << size)) - 1) << byte_off);

  assign dword_sel = rd_block_i[dword_idx*64 +: 64];
  assign shifted = dword_sel >> {byte_off, 3'b000};
  assign placed = store_data_i << {byte_off, 3'b000};

  always_comb begin
    case (size)
      2'd0: load_dword_o = {{56{is_signed & shifted[7]}}, shifted[7:0]};
      2'd1: load_dword_o = {{48{is_signed & shifted[15]}}, shifted[15:0]};
      2'd2: load_dword_o = {{32{is_signed & shifted[31]}}, shifted[31:0]};
      default: load_dword_o = shifted;
    endcase
  end

  always_comb begin
    logic [block_width_p-1:0] mask_wide;
    logic [block_width_p-1:0] data_wide;
    for (int b = 0; b < 8; b++) begin
      bit_mask[8*b +: 8] = {8{byte_mask[b]}};
    end
    mask_wide = '0;
    data_wide = '0;
    mask_wide[63:0] = bit_mask;
    data_wide[63:0] = placed;
    // move the dword lane into place within the line
    store_mask_o = mask_wide << (dword_idx * 64);
    store_block_o = data_wide << (dword_idx * 64);
  end

endmodule

// ==== design/lce_pkg.sv ====
package lce_pkg;

  // widths seen on the trace port
  typedef logic [31:0] paddr_t;
  typedef logic [63:0] dword_t;

  // byte offset bits inside one dword
  localparam int LG_DWORD_BYTES = 3;

  // bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size
  typedef enum logic [3:0] {
    op_lb  = 4'b0000,
    op_lh  = 4'b0001,
    op_lw  = 4'b0010,
    op_ld  = 4'b0011,
    op_lbu = 4'b0100,
    op_lhu = 4'b0101,
    op_lwu = 4'b0110,
    op_ldu = 4'b0111,
    op_sb  = 4'b1000,
    op_sh  = 4'b1001,
    op_sw  = 4'b1010,
    op_sd  = 4'b1011
  } tr_op_e;

  // no shared state, so a store to E simply moves the line to M
  typedef enum logic [1:0] {
    coh_i = 2'd0,
    coh_e = 2'd1,
    coh_m = 2'd2
  } coh_state_e;

  typedef enum logic {req_rd = 1'b0, req_wr = 1'b1} req_type_e;

  typedef enum logic {cmd_fill = 1'b0, cmd_wb = 1'b1} cmd_type_e;

  typedef enum logic [1:0] {
    resp_coh_ack = 2'd0,
    resp_wb      = 2'd1,
    resp_null_wb = 2'd2
  } resp_type_e;

endpackage
